// ==== logic/lc3Pkg.sv ====
package lc3Pkg;

    // datapath sizes
    localparam int wordW   = 16;
    localparam int regIdxW = 3;
    localparam int numRegs = 8;

    localparam logic [wordW-1:0] resetPc = 16'h3000;   // LC-3 user space start

    // opcodes of the supported subset, LC-3 encoding
    localparam logic [3:0] opBr  = 4'b0000;
    localparam logic [3:0] opAdd = 4'b0001;
    localparam logic [3:0] opJsr = 4'b0100;
    localparam logic [3:0] opAnd = 4'b0101;
    localparam logic [3:0] opNot = 4'b1001;
    localparam logic [3:0] opLea = 4'b1110;

    // condition codes in nzp order, same bit positions as the BR mask in IR[11:9]
    localparam logic [2:0] ccN = 3'b100;
    localparam logic [2:0] ccZ = 3'b010;
    localparam logic [2:0] ccP = 3'b001;

    // ALU operation select
    localparam logic [1:0] aluAdd = 2'd0;
    localparam logic [1:0] aluAnd = 2'd1;
    localparam logic [1:0] aluNot = 2'd2;

    // sequencer states
    localparam logic [1:0] stIdle = 2'd0;   // waiting for an instruction
    localparam logic [1:0] stExec = 2'd1;   // decode and branch resolve
    localparam logic [1:0] stWb   = 2'd2;   // writeback offered, wait for ready

    // source of the internal bus
    typedef enum logic [1:0] {
        busAlu,     // ALU result
        busLea,     // PC+1+sext(offset9)
        busLink     // PC+1
    } busSelE;

    // operate instructions carry either a register or an imm5 as second operand,
    // immFlag (bit 5) tells which view applies
    typedef union packed {
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dr;
            logic [2:0] sr1;
            logic       immFlag;
            logic [1:0] pad;
            logic [2:0] sr2;
        } opReg;
        struct packed {
            logic [3:0] opcode;
            logic [2:0] dr;
            logic [2:0] sr1;
            logic       immFlag;
            logic [4:0] imm5;
        } opImm;
    } lc3InstrU;

endpackage

// ==== logic/regFile.sv ====
`timescale 1ns/1ns

module regFile (
    input  logic                       Clk,
    input  logic                       rstN,
    input  logic                       ldReg,
    input  logic                       drSel,     // 1 forces R7 for JSR
    input  logic [lc3Pkg::regIdxW-1:0] irDr,
    input  logic [lc3Pkg::regIdxW-1:0] sr1Idx,
    input  logic [lc3Pkg::regIdxW-1:0] sr2Idx,
    input  logic [lc3Pkg::wordW-1:0]   d,
    output logic [lc3Pkg::wordW-1:0]   sr1Out,
    output logic [lc3Pkg::wordW-1:0]   sr2Out,
    output logic [lc3Pkg::regIdxW-1:0] wrIdx
);
    import lc3Pkg::*;

    logic [wordW-1:0]   regs [numRegs];
    logic [numRegs-1:0] loadEn;

    // destination mux
    assign wrIdx = drSel ? regIdxW'(numRegs - 1) : irDr;

    // one-hot write decode, nothing enabled unless ldReg
    always_comb
    begin
        loadEn = '0;
        if (ldReg)
        begin
            for (int i = 0; i < numRegs; i++)
            begin
                if (wrIdx == regIdxW'(i))
                    loadEn[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end
        else
        begin
            for (int i = 0; i < numRegs; i++)
            begin
                if (loadEn[i])
                    regs[i] <= d;
            end
        end
    end

    // two independent read ports
    always_comb
    begin
        sr1Out = regs[0];
        sr2Out = regs[0];
        for (int i = 1; i < numRegs; i++)
        begin
            if (sr1Idx == regIdxW'(i))
                sr1Out = regs[i];
            if (sr2Idx == regIdxW'(i))
                sr2Out = regs[i];
        end
    end

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ns

module aluUnit (
    input  logic [1:0]               aluOp,
    input  lc3Pkg::lc3InstrU         ir,
    input  logic [lc3Pkg::wordW-1:0] srcA,
    input  logic [lc3Pkg::wordW-1:0] srcB,
    output logic [lc3Pkg::wordW-1:0] aluOut
);
    import lc3Pkg::*;

    logic [wordW-1:0] immExt;
    logic [wordW-1:0] opB;

    // sign extend imm5 to the full word
    assign immExt = {{(wordW - 5){ir.opImm.imm5[4]}}, ir.opImm.imm5};

    // second operand, register form vs immediate form
    always_comb
    begin
        if (ir.opReg.immFlag)
            opB = immExt;
        else
            opB = srcB;
    end

    always_comb
    begin
        unique case (aluOp)
            aluAdd  : aluOut = srcA + opB;
            aluAnd  : aluOut = srcA & opB;
            aluNot  : aluOut = ~srcA;     // NOT ignores the second operand
            default : aluOut = srcA;
        endcase
    end

endmodule

// ==== logic/pcCcUnit.sv ====
`timescale 1ns/1ns

module pcCcUnit (
    input  logic                     Clk,
    input  logic                     rstN,
    input  lc3Pkg::lc3InstrU         ir,
    input  logic                     ldPc,
    input  logic                     ldCc,
    input  lc3Pkg::busSelE           busSel,
    input  logic [lc3Pkg::wordW-1:0] aluOut,
    output logic [lc3Pkg::wordW-1:0] busOut,
    output logic [lc3Pkg::wordW-1:0] pc,
    output logic                     branchTaken
);
    import lc3Pkg::*;

    logic [wordW-1:0] pcPlus1;
    logic [wordW-1:0] leaAddr;
    logic [wordW-1:0] jsrTarget;
    logic [wordW-1:0] pcNext;
    logic [2:0]       cc;

    assign pcPlus1   = pc + 1'b1;                                  // also the JSR link
    assign leaAddr   = pcPlus1 + {{(wordW - 9){ir[8]}}, ir[8:0]};   // LEA and BR target
    assign jsrTarget = pcPlus1 + {{(wordW - 11){ir[10]}}, ir[10:0]};

    always_comb
    begin
        unique case (busSel)
            busLea  : busOut = leaAddr;
            busLink : busOut = pcPlus1;
            default : busOut = aluOut;
        endcase
    end

    // BR takes its next PC from the bus, where the sequencer has already
    // picked the target or the fall-through address
    always_comb
    begin
        if (ir.opReg.opcode == opJsr)
            pcNext = jsrTarget;
        else if (ir.opReg.opcode == opBr)
            pcNext = busOut;
        else
            pcNext = pcPlus1;
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            pc <= resetPc;
        else if (ldPc)
            pc <= pcNext;
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            cc <= ccZ;
        else if (ldCc)
        begin
            if (busOut[wordW-1])
                cc <= ccN;
            else if (busOut == '0)
                cc <= ccZ;
            else
                cc <= ccP;
        end
    end

    assign branchTaken = |(ir[11:9] & cc);   // nzp mask against current flags

endmodule

// ==== logic/controlFsm.sv ====
`timescale 1ns/1ns

module controlFsm (
    input  logic                     Clk,
    input  logic                     rstN,
    input  logic                     instrValid,
    input  logic [lc3Pkg::wordW-1:0] instr,
    output logic                     instrReady,
    output logic                     wbValid,
    input  logic                     wbReady,
    input  logic                     branchTaken,
    output lc3Pkg::lc3InstrU         ir,
    output logic                     ldReg,
    output logic                     ldPc,
    output logic                     ldCc,
    output logic                     drSel,
    output lc3Pkg::busSelE           busSel,
    output logic [1:0]               aluOp
);
    import lc3Pkg::*;

    logic [1:0] state;
    logic [1:0] stateNext;
    logic [3:0] opcode;
    logic       hasWb;      // instruction writes a register

    assign opcode = ir.opReg.opcode;

    assign instrReady = (state == stIdle);
    assign wbValid    = (state == stWb);

    // IR only changes on an accepted transfer
    always_ff @(posedge Clk)
    begin
        if (instrValid && instrReady)
            ir <= instr;
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            state <= stIdle;
        else
            state <= stateNext;
    end

    // opcode decode
    always_comb
    begin
        busSel = busAlu;
        aluOp  = aluAdd;
        drSel  = 1'b0;
        hasWb  = 1'b0;
        unique case (opcode)
            opAdd :
            begin
                aluOp = aluAdd;
                hasWb = 1'b1;
            end
            opAnd :
            begin
                aluOp = aluAnd;
                hasWb = 1'b1;
            end
            opNot :
            begin
                aluOp = aluNot;
                hasWb = 1'b1;
            end
            opLea :
            begin
                busSel = busLea;
                hasWb  = 1'b1;
            end
            opJsr :
            begin
                busSel = busLink;   // R7 gets the return address
                drSel  = 1'b1;
                hasWb  = 1'b1;
            end
            opBr :
                busSel = branchTaken ? busLea : busLink;
            default :
                busSel = busAlu;    // unknown opcode, no-op
        endcase
    end

    // sequencer and load strobes
    always_comb
    begin
        stateNext = state;
        ldReg     = 1'b0;
        ldPc      = 1'b0;
        ldCc      = 1'b0;
        unique case (state)
            stIdle :
            begin
                if (instrValid)
                    stateNext = stExec;
            end
            stExec :
            begin
                if (hasWb)
                    stateNext = stWb;
                else
                begin
                    ldPc      = 1'b1;   // BR resolve or no-op advance
                    stateNext = stIdle;
                end
            end
            stWb :
            begin
                if (wbReady)
                begin
                    ldReg     = 1'b1;
                    ldPc      = 1'b1;
                    ldCc      = (opcode != opJsr);
                    stateNext = stIdle;
                end
            end
            default :
                stateNext = stIdle;
        endcase
    end

endmodule

// ==== logic/lc3Core.sv ====
`timescale 1ns/1ns

module lc3Core (
    input  logic                       Clk,
    input  logic                       rstN,
    input  logic                       instrValid,
    input  logic [lc3Pkg::wordW-1:0]   instr,
    output logic                       instrReady,
    output logic                       wbValid,
    input  logic                       wbReady,
    output logic [lc3Pkg::regIdxW-1:0] wbReg,
    output logic [lc3Pkg::wordW-1:0]   wbData
);
    import lc3Pkg::*;

    lc3InstrU         ir;
    busSelE           busSel;
    logic [1:0]       aluOp;
    logic             ldReg;
    logic             ldPc;
    logic             ldCc;
    logic             drSel;
    logic             branchTaken;
    logic [wordW-1:0] sr1Out;
    logic [wordW-1:0] sr2Out;
    logic [wordW-1:0] aluOut;

    controlFsm i_ctrl (
        .Clk         (Clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .wbValid     (wbValid),
        .wbReady     (wbReady),
        .branchTaken (branchTaken),
        .ir          (ir),
        .ldReg       (ldReg),
        .ldPc        (ldPc),
        .ldCc        (ldCc),
        .drSel       (drSel),
        .busSel      (busSel),
        .aluOp       (aluOp)
    );

    // the bus is both the register write data and the reported writeback
    regFile i_regs (
        .Clk    (Clk),
        .rstN   (rstN),
        .ldReg  (ldReg),
        .drSel  (drSel),
        .irDr   (ir.opReg.dr),
        .sr1Idx (ir.opReg.sr1),
        .sr2Idx (ir.opReg.sr2),
        .d      (wbData),
        .sr1Out (sr1Out),
        .sr2Out (sr2Out),
        .wrIdx  (wbReg)
    );

    aluUnit i_alu (
        .aluOp  (aluOp),
        .ir     (ir),
        .srcA   (sr1Out),
        .srcB   (sr2Out),
        .aluOut (aluOut)
    );

    pcCcUnit i_pcCc (
        .Clk         (Clk),
        .rstN        (rstN),
        .ir          (ir),
        .ldPc        (ldPc),
        .ldCc        (ldCc),
        .busSel      (busSel),
        .aluOut      (aluOut),
        .busOut      (wbData),
        .pc          (),
        .branchTaken (branchTaken)
    );

endmodule

// ==== test/lc3CoreTb.sv ====
`timescale 1ns/1ns

module lc3CoreTb;
    import lc3Pkg::*;

    localparam int waitLimit = 50;   // cycles per wait loop

    logic               Clk;
    logic               rstN;
    logic               instrValid;
    logic [wordW-1:0]   instr;
    logic               instrReady;
    logic               wbValid;
    logic               wbReady;
    logic [regIdxW-1:0] wbReg;
    logic [wordW-1:0]   wbData;

    // reference state of the core
    logic [wordW-1:0] modelRegs [numRegs];
    logic [wordW-1:0] modelPc;
    logic [2:0]       modelCc;

    int seed;
    bit holdWb;   // stretch writebacks with wbReady low

    lc3Core i_dut (
        .Clk        (Clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .wbValid    (wbValid),
        .wbReady    (wbReady),
        .wbReg      (wbReg),
        .wbData     (wbData)
    );

    always #50 Clk = ~Clk;

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareWord(input logic [wordW-1:0] got, input logic [wordW-1:0] exp,
                               input string what);
        if (got !== exp)
            stopRun($sformatf("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic compareReg(input logic [regIdxW-1:0] got, input logic [regIdxW-1:0] exp,
                              input string what);
        if (got !== exp)
            stopRun($sformatf("[FAIL] %0t: %s is R%0d, expected R%0d", $time, what, got, exp));
    endtask

    task automatic compareBit(input logic got, input logic exp, input string what);
        if (got !== exp)
            stopRun($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    function automatic logic [wordW-1:0] signExtend(input logic [10:0] field, input int width);
        logic [wordW-1:0] r;
        r = wordW'(field);
        for (int i = width; i < wordW; i++)
            r[i] = field[width-1];
        return r;
    endfunction

    function automatic logic [2:0] flagsOf(input logic [wordW-1:0] value);
        if (value[wordW-1])
            return 3'b100;
        else if (value == '0)
            return 3'b010;
        else
            return 3'b001;
    endfunction

    // instruction word builders, LC-3 layout
    function automatic logic [wordW-1:0] operateWord(input logic [3:0] op,
            input logic [2:0] dr, input logic [2:0] sr1, input bit useImm, input logic [4:0] low5);
        return {op, dr, sr1, useImm, low5};
    endfunction

    function automatic logic [wordW-1:0] leaWord(input logic [2:0] dr, input logic [8:0] off9);
        return {opLea, dr, off9};
    endfunction

    function automatic logic [wordW-1:0] branchWord(input logic [2:0] nzp, input logic [8:0] off9);
        return {opBr, nzp, off9};
    endfunction

    function automatic logic [wordW-1:0] jsrWord(input logic [10:0] off11);
        return {opJsr, 1'b1, off11};
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic sendInstr(input logic [wordW-1:0] word);
        int cnt;
        instrValid = 1'b1;
        instr      = word;
        cnt        = 0;
        while (!instrReady)
        begin
            @(negedge Clk);
            cnt++;
            if (cnt > waitLimit)
                stopRun("timeout: the core never raised instrReady");
        end
        @(negedge Clk);
        instrValid = 1'b0;
    endtask

    task automatic expectWb(input logic [regIdxW-1:0] expReg, input logic [wordW-1:0] expData,
                            input bit updCc, input logic [wordW-1:0] nextPc);
        int                 cnt;
        int                 holdCycles;
        logic [regIdxW-1:0] heldReg;
        logic [wordW-1:0]   heldData;
        cnt = 0;
        while (!wbValid)
        begin
            @(negedge Clk);
            cnt++;
            if (cnt > waitLimit)
                stopRun("timeout: the core never raised wbValid");
        end
        if (holdWb)
        begin
            holdCycles = {$random(seed)} % 6;
            heldReg    = wbReg;
            heldData   = wbData;
            repeat (holdCycles)
            begin
                @(negedge Clk);
                compareBit(wbValid, 1'b1, "wbValid under back-pressure");
                compareBit(instrReady, 1'b0, "instrReady under back-pressure");
                compareReg(wbReg, heldReg, "wbReg under back-pressure");
                compareWord(wbData, heldData, "wbData under back-pressure");
                compareWord(i_dut.i_regs.regs[expReg], modelRegs[expReg],
                            "destination register before handshake");
            end
        end
        compareReg(wbReg, expReg, "wbReg");
        compareWord(wbData, expData, "wbData");
        wbReady = 1'b1;
        @(negedge Clk);
        wbReady = 1'b0;
        compareWord(i_dut.i_regs.regs[expReg], expData, "destination register after handshake");
        modelRegs[expReg] = expData;
        if (updCc)
            modelCc = flagsOf(expData);
        modelPc = nextPc;
    endtask

    task automatic runOp(input logic [3:0] op, input logic [2:0] dr, input logic [2:0] sr1,
                         input bit useImm, input logic [4:0] low5);
        logic [wordW-1:0] opB;
        logic [wordW-1:0] result;
        opB = useImm ? signExtend(11'(low5), 5) : modelRegs[low5[2:0]];
        if (op == opAdd)
            result = modelRegs[sr1] + opB;
        else if (op == opAnd)
            result = modelRegs[sr1] & opB;
        else
            result = ~modelRegs[sr1];   // NOT
        sendInstr(operateWord(op, dr, sr1, useImm, low5));
        expectWb(dr, result, 1'b1, modelPc + 16'd1);
    endtask

    task automatic runLea(input logic [2:0] dr, input logic [8:0] off9);
        logic [wordW-1:0] addr;
        addr = modelPc + 16'd1 + signExtend(11'(off9), 9);
        sendInstr(leaWord(dr, off9));
        expectWb(dr, addr, 1'b1, modelPc + 16'd1);
    endtask

    task automatic runBranch(input logic [2:0] nzp, input logic [8:0] off9);
        bit taken;
        int cnt;
        taken = |(nzp & modelCc);
        sendInstr(branchWord(nzp, off9));
        cnt = 0;
        while (!instrReady)
        begin
            compareBit(wbValid, 1'b0, "wbValid during BR");
            @(negedge Clk);
            cnt++;
            if (cnt > waitLimit)
                stopRun("timeout: the core never finished a branch");
        end
        if (taken)
            modelPc = modelPc + 16'd1 + signExtend(11'(off9), 9);
        else
            modelPc = modelPc + 16'd1;
    endtask

    task automatic runJsr(input logic [10:0] off11);
        logic [wordW-1:0] link;
        link = modelPc + 16'd1;
        sendInstr(jsrWord(off11));
        expectWb(3'd7, link, 1'b0, link + signExtend(off11, 11));   // link goes to R7
    endtask

    // clear then add, so any imm5 value can be placed
    task automatic loadReg(input logic [2:0] r, input logic [4:0] imm5);
        runOp(opAnd, r, r, 1'b1, 5'd0);
        runOp(opAdd, r, r, 1'b1, imm5);
    endtask

    task automatic loadWide(input logic [2:0] r);
        loadReg(r, 5'($random(seed)));
        repeat ({$random(seed)} % 11)
            runOp(opAdd, r, r, 1'b0, {2'b00, r});   // doubling widens the value
    endtask

    task automatic testReset;
        compareBit(instrReady, 1'b1, "instrReady after reset");
        compareBit(wbValid, 1'b0, "wbValid after reset");
        runLea(3'd3, 9'd0);
    endtask

    task automatic testAlu;
        logic [2:0] ra;
        logic [2:0] rb;
        logic [2:0] dr;
        repeat (8)
        begin
            ra = 3'($random(seed));
            rb = 3'($random(seed));
            dr = 3'($random(seed));
            loadWide(ra);
            loadWide(rb);
            runOp(opAdd, dr, ra, 1'b0, {2'b00, rb});
            runOp(opAdd, dr, ra, 1'b1, 5'($random(seed)));
            runOp(opAnd, dr, ra, 1'b0, {2'b00, rb});
            runOp(opAnd, dr, ra, 1'b1, 5'($random(seed)));
            runOp(opNot, dr, ra, 1'b1, 5'h1f);
        end
    endtask

    task automatic testDecode;
        for (int r = 0; r < numRegs; r++)
            loadReg(3'(r), 5'($random(seed)));
        for (int r = 0; r < numRegs; r++)
            runOp(opAdd, 3'(r), 3'(r), 1'b1, 5'd0);   // read back through the writeback
    endtask

    task automatic testBranch;
        logic [4:0] flagVal;
        for (int v = 0; v < 3; v++)
        begin
            flagVal = (v == 0) ? 5'h1d : ((v == 1) ? 5'h00 : 5'h06);
            for (int mask = 0; mask < 8; mask++)
            begin
                loadReg(3'd2, flagVal);
                runBranch(3'(mask), 9'($random(seed)));
                runLea(3'd4, 9'd0);
            end
        end
    endtask

    task automatic testJsr;
        repeat (4)
        begin
            loadReg(3'd2, 5'd0);   // Z flag, JSR leaves it alone
            runJsr(11'($random(seed)));
            runBranch(3'b010, 9'($random(seed)));
            runLea(3'd5, 9'd0);
        end
    endtask

    task automatic testBackPressure;
        holdWb = 1'b1;
        repeat (6)
        begin
            loadWide(3'($random(seed)));
            runOp(opAdd, 3'($random(seed)), 3'($random(seed)), 1'b0, 5'($random(seed) & 7));
            runJsr(11'($random(seed)));
            runLea(3'($random(seed)), 9'($random(seed)));
        end
        holdWb = 1'b0;
    endtask

    initial
    begin
        Clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        wbReady    = 1'b0;
        seed       = 34;
        holdWb     = 1'b0;
        modelPc    = resetPc;
        modelCc    = ccZ;
        for (int r = 0; r < numRegs; r++)
            modelRegs[r] = '0;
        repeat (3) @(negedge Clk);
        rstN = 1'b1;

        testReset;
        testAlu;
        testDecode;
        testBranch;
        testJsr;
        testBackPressure;

        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
logic/lc3Pkg.sv
logic/regFile.sv
logic/aluUnit.sv
logic/pcCcUnit.sv
logic/controlFsm.sv
logic/lc3Core.sv
test/lc3CoreTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the LC-3 core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module lc3CoreTb \
    -f sources.f \
    -o lc3CoreSim

./obj_dir/lc3CoreSim
